//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////////////////////

    // 4 KiB total, 2 ways of 64 sets, 32 B lines
    localparam int LINE_BYTES = 32;
    localparam int SET_NUM    = 64;
    localparam int WAY_NUM    = 2;

    // address split is tag | index | offset
    localparam int ADDR_W     = 32;
    localparam int OFFT_LEN   = $clog2(LINE_BYTES);
    localparam int INDEX_LEN  = $clog2(SET_NUM);
    localparam int TAG_LEN    = ADDR_W - INDEX_LEN - OFFT_LEN;

    ////////////////////////////////////////////////////////////////////////////
    // data widths and burst shape
    ////////////////////////////////////////////////////////////////////////////

    localparam int INST_W     = 32;
    localparam int LINE_W     = LINE_BYTES * 8;
    // two banks per way
    localparam int BANK_W     = 128;
    localparam int BANK_NUM   = 4;
    // fixed burst of four 8-byte beats
    localparam int BEAT_W     = 64;
    localparam int BEAT_NUM   = LINE_W / BEAT_W;

    ////////////////////////////////////////////////////////////////////////////
    // miss/refill FSM
    ////////////////////////////////////////////////////////////////////////////

    // one-hot
    typedef enum logic [4:0] {
        IDLE        = 5'b00001,
        RD_HIT      = 5'b00010,
        RD_MISS     = 5'b00100,
        RD_RELOAD   = 5'b01000,
        RD_ALLOCATE = 5'b10000
    } icache_state_t;

endpackage

`default_nettype wire

//--- src/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
    input  logic                             I_clk,
    // active low enable and write enable
    input  logic                             cen,
    input  logic                             wen,
    // bit is written where wmask_n is 0
    input  logic [icache_pkg::BANK_W-1:0]    wmask_n,
    input  logic [icache_pkg::INDEX_LEN-1:0] addr,
    input  logic [icache_pkg::BANK_W-1:0]    wdata,
    output logic [icache_pkg::BANK_W-1:0]    rdata
);

    // one entry per set
    logic [icache_pkg::BANK_W-1:0] mem [icache_pkg::SET_NUM];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    // masked bits keep their old value
    always_ff @(posedge I_clk) begin
        if (!cen && !wen) begin
            mem[addr] <= (mem[addr] & wmask_n) | (wdata & ~wmask_n);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    // asynchronous, zero when the bank is off
    assign rdata = cen ? '0 : mem[addr];

endmodule

`default_nettype wire

//--- icache/icache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  logic [icache_pkg::ADDR_W-1:0] lookup_addr,
    input  logic                          cpu_req,
    input  logic [icache_pkg::ADDR_W-1:0] miss_addr,
    input  logic                          allocate,
    output logic                          hit,
    output logic                          hit_way,
    output logic                          victim_way
);

    // lookup side fields
    logic [icache_pkg::TAG_LEN-1:0]   lookup_tag;
    logic [icache_pkg::INDEX_LEN-1:0] lookup_index;
    // refill side fields
    logic [icache_pkg::TAG_LEN-1:0]   miss_tag;
    logic [icache_pkg::INDEX_LEN-1:0] miss_index;

    // per set, per way
    logic [icache_pkg::TAG_LEN-1:0] tag_tbl [icache_pkg::SET_NUM][icache_pkg::WAY_NUM];
    logic [icache_pkg::WAY_NUM-1:0] valid_tbl [icache_pkg::SET_NUM];

    logic [icache_pkg::WAY_NUM-1:0] way_hit;
    logic [icache_pkg::WAY_NUM-1:0] miss_set_valid;

    assign lookup_tag   = lookup_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_LEN];
    assign lookup_index = lookup_addr[icache_pkg::OFFT_LEN +: icache_pkg::INDEX_LEN];
    assign miss_tag     = miss_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_LEN];
    assign miss_index   = miss_addr[icache_pkg::OFFT_LEN +: icache_pkg::INDEX_LEN];

    ////////////////////////////////////////////////////////////////////////////
    // hit detection
    ////////////////////////////////////////////////////////////////////////////

    // compare both ways of the requested set
    always_comb begin
        for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
            way_hit[w] = cpu_req && valid_tbl[lookup_index][w]
                         && (tag_tbl[lookup_index][w] == lookup_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // victim choice
    // way 1 only while it is still empty and way 0 is taken
    assign miss_set_valid = valid_tbl[miss_index];
    assign victim_way     = miss_set_valid[0] && !miss_set_valid[1];

    ////////////////////////////////////////////////////////////////////////////
    // table update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            for (int s = 0; s < icache_pkg::SET_NUM; s++) begin
                valid_tbl[s] <= '0;
            end
        end else if (allocate) begin
            valid_tbl[miss_index][victim_way] <= 1'b1;
        end
    end

    // tag installed in the same edge as the valid bit
    always_ff @(posedge I_clk) begin
        if (allocate) begin
            tag_tbl[miss_index][victim_way] <= miss_tag;
        end
    end

    // refills only follow misses, so a tag never sits in both ways of a set
    a_single_way_hit : assert property (@(posedge I_clk) disable iff (I_rst)
        !(&way_hit));

endmodule

`default_nettype wire

//--- icache/icache_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module icache_line_buffer (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  logic                          capture_hit,
    input  logic                          hit_way,
    input  logic [icache_pkg::LINE_W-1:0] way0_rdata,
    input  logic [icache_pkg::LINE_W-1:0] way1_rdata,
    input  logic                          reload,
    input  logic                          mem_rvalid,
    input  logic [icache_pkg::BEAT_W-1:0] mem_rdata,
    input  logic [2:0]                    word_sel,
    output logic [icache_pkg::LINE_W-1:0] line,
    output logic [icache_pkg::INST_W-1:0] inst
);

    // bit offset of the selected word
    logic [7:0] word_base;

    ////////////////////////////////////////////////////////////////////////////
    // line register
    ////////////////////////////////////////////////////////////////////////////

    // hit path
    // banks read asynchronously, taken at the edge that leaves IDLE
    // refill path
    // beats enter at the top and move down, first beat ends in bits 63:0
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            line <= '0;
        end else if (capture_hit) begin
            line <= hit_way ? way1_rdata : way0_rdata;
        end else if (reload && mem_rvalid) begin
            line <= {mem_rdata, line[icache_pkg::LINE_W-1:icache_pkg::BEAT_W]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word select
    ////////////////////////////////////////////////////////////////////////////

    // addr bits 4:2 times 32
    assign word_base = {word_sel, 5'b00000};
    assign inst      = line[word_base +: icache_pkg::INST_W];

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                             I_clk,
    input  logic                             I_rst,
    // cpu fetch port
    input  logic                             cpu_req,
    input  logic [icache_pkg::ADDR_W-1:0]    cpu_addr,
    output logic                             cpu_rvalid,
    // from tag store
    input  logic                             hit,
    input  logic                             hit_way,
    input  logic                             victim_way,
    // memory read channels
    input  logic                             mem_arready,
    input  logic                             mem_rvalid,
    input  logic                             mem_rlast,
    output logic                             mem_arvalid,
    output logic [icache_pkg::ADDR_W-1:0]    mem_araddr,
    // lookup and line buffer control
    output logic [icache_pkg::ADDR_W-1:0]    lookup_addr,
    output logic                             allocate,
    output logic                             reload,
    output logic                             capture_hit,
    // sram banks 3..0, all active low
    output logic [icache_pkg::INDEX_LEN-1:0] sram_addr,
    output logic [icache_pkg::BANK_NUM-1:0]  sram_cen,
    output logic [icache_pkg::BANK_NUM-1:0]  sram_wen,
    output logic [icache_pkg::BANK_NUM-1:0]  sram_wmask_n
);

    icache_pkg::icache_state_t state_q;
    icache_pkg::icache_state_t state_d;

    // request address, also the miss address
    logic [icache_pkg::ADDR_W-1:0] req_addr_q;
    logic                          in_idle;

    ////////////////////////////////////////////////////////////////////////////
    // state register and next state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // lookup happens here
            icache_pkg::IDLE: begin
                if (cpu_req) begin
                    state_d = hit ? icache_pkg::RD_HIT : icache_pkg::RD_MISS;
                end
            end
            // word returned, one cycle
            icache_pkg::RD_HIT:      state_d = icache_pkg::IDLE;
            // hold arvalid until arready
            icache_pkg::RD_MISS: begin
                if (mem_arready) begin
                    state_d = icache_pkg::RD_RELOAD;
                end
            end
            // gather beats
            icache_pkg::RD_RELOAD: begin
                if (mem_rvalid && mem_rlast) begin
                    state_d = icache_pkg::RD_ALLOCATE;
                end
            end
            // write victim, install tag, return word
            icache_pkg::RD_ALLOCATE: state_d = icache_pkg::IDLE;
            default:                 state_d = icache_pkg::IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // address latch and lookup address
    ////////////////////////////////////////////////////////////////////////////

    // cpu holds addr until rvalid
    always_ff @(posedge I_clk) begin
        if (cpu_req) begin
            req_addr_q <= cpu_addr;
        end
    end

    assign in_idle     = (state_q == icache_pkg::IDLE);
    // live address while idle, latched copy afterwards
    assign lookup_addr = in_idle ? cpu_addr : req_addr_q;
    assign sram_addr   = lookup_addr[icache_pkg::OFFT_LEN +: icache_pkg::INDEX_LEN];

    // line aligned burst address
    assign mem_araddr  = {req_addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFFT_LEN],
                          {icache_pkg::OFFT_LEN{1'b0}}};
    assign mem_arvalid = (state_q == icache_pkg::RD_MISS);

    assign reload      = (state_q == icache_pkg::RD_RELOAD);
    assign allocate    = (state_q == icache_pkg::RD_ALLOCATE);
    assign capture_hit = in_idle && hit;
    assign cpu_rvalid  = (state_q == icache_pkg::RD_HIT) || allocate;

    ////////////////////////////////////////////////////////////////////////////
    // bank control
    ////////////////////////////////////////////////////////////////////////////

    // way 0 -> banks 1:0, way 1 -> banks 3:2
    always_comb begin
        sram_cen     = '1;
        sram_wen     = '1;
        sram_wmask_n = '1;
        if (capture_hit) begin
            // read the hit pair
            sram_cen = hit_way ? 4'b0011 : 4'b1100;
        end else if (allocate) begin
            // full line write into the victim pair
            sram_cen     = victim_way ? 4'b0011 : 4'b1100;
            sram_wen     = victim_way ? 4'b0011 : 4'b1100;
            sram_wmask_n = victim_way ? 4'b0011 : 4'b1100;
        end
    end

    // address request stays up and steady until the memory takes it
    a_arvalid_held : assert property (@(posedge I_clk) disable iff (I_rst)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

    // only one way's banks enabled in any cycle
    a_one_bank_pair : assert property (@(posedge I_clk) disable iff (I_rst)
        (&sram_cen[1:0]) || (&sram_cen[3:2]));

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                          I_clk,
    input  logic                          I_rst,
    // cpu fetch port
    input  logic                          cpu_req,
    input  logic [icache_pkg::ADDR_W-1:0] cpu_addr,
    output logic [icache_pkg::INST_W-1:0] cpu_inst,
    output logic                          cpu_rvalid,
    // memory read channels
    input  logic                          mem_arready,
    input  logic                          mem_rvalid,
    input  logic [icache_pkg::BEAT_W-1:0] mem_rdata,
    input  logic                          mem_rlast,
    output logic                          mem_arvalid,
    output logic [icache_pkg::ADDR_W-1:0] mem_araddr
);

    logic [icache_pkg::ADDR_W-1:0]    lookup_addr;
    logic                             allocate;
    logic                             reload;
    logic                             capture_hit;
    logic                             hit;
    logic                             hit_way;
    logic                             victim_way;
    logic [icache_pkg::INDEX_LEN-1:0] sram_addr;
    logic [icache_pkg::BANK_NUM-1:0]  sram_cen;
    logic [icache_pkg::BANK_NUM-1:0]  sram_wen;
    logic [icache_pkg::BANK_NUM-1:0]  sram_wmask_n;
    logic [icache_pkg::LINE_W-1:0]    line;
    // bank 0 lowest, pairs 1:0 and 3:2 form the way lines
    logic [icache_pkg::BANK_NUM-1:0][icache_pkg::BANK_W-1:0] bank_rdata;

    icache_ctrl i_ctrl (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .cpu_rvalid   (cpu_rvalid),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .mem_arready  (mem_arready),
        .mem_rvalid   (mem_rvalid),
        .mem_rlast    (mem_rlast),
        .mem_arvalid  (mem_arvalid),
        .mem_araddr   (mem_araddr),
        .lookup_addr  (lookup_addr),
        .allocate     (allocate),
        .reload       (reload),
        .capture_hit  (capture_hit),
        .sram_addr    (sram_addr),
        .sram_cen     (sram_cen),
        .sram_wen     (sram_wen),
        .sram_wmask_n (sram_wmask_n)
    );

    // victim choice keys off the latched miss address
    icache_tag_store i_tag_store (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .lookup_addr (lookup_addr),
        .cpu_req     (cpu_req),
        .miss_addr   (mem_araddr),
        .allocate    (allocate),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    icache_line_buffer i_line_buffer (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .capture_hit (capture_hit),
        .hit_way     (hit_way),
        .way0_rdata  (bank_rdata[1:0]),
        .way1_rdata  (bank_rdata[3:2]),
        .reload      (reload),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .word_sel    (lookup_addr[icache_pkg::OFFT_LEN-1:2]),
        .line        (line),
        .inst        (cpu_inst)
    );

    // even banks hold the low half of a line, odd banks the high half
    for (genvar g = 0; g < icache_pkg::BANK_NUM; g++) begin : g_bank
        sram_bank i_bank (
            .I_clk   (I_clk),
            .cen     (sram_cen[g]),
            .wen     (sram_wen[g]),
            .wmask_n ({icache_pkg::BANK_W{sram_wmask_n[g]}}),
            .addr    (sram_addr),
            .wdata   (line[(g % 2) * icache_pkg::BANK_W +: icache_pkg::BANK_W]),
            .rdata   (bank_rdata[g])
        );
    end

endmodule

`default_nettype wire

//--- testbench/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  logic                          I_clk,
    input  logic                          I_rst,
    // back-pressure request from the testbench
    input  logic                          stall,
    // read address channel
    input  logic                          arvalid,
    input  logic [icache_pkg::ADDR_W-1:0] araddr,
    output logic                          arready,
    // read data channel, always accepted by the cache
    output logic                          rvalid,
    output logic [icache_pkg::BEAT_W-1:0] rdata,
    output logic                          rlast
);

    // burst in progress
    logic                          busy = 1'b0;
    logic [1:0]                    beat = 2'd0;
    logic [icache_pkg::ADDR_W-1:0] base = '0;
    // byte address of the current beat
    logic [icache_pkg::ADDR_W-1:0] beat_addr;

    // memory contents follow from the byte address alone
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'hC0DE_0000;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // burst sequencing
    ////////////////////////////////////////////////////////////////////////////

    // one fixed four beat burst per accepted address
    always @(posedge I_clk) begin
        if (I_rst) begin
            busy <= 1'b0;
            beat <= 2'd0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy <= 1'b1;
                beat <= 2'd0;
                base <= araddr;
            end
        end else begin
            beat <= beat + 2'd1;
            if (beat == 2'(icache_pkg::BEAT_NUM - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // no new address while a burst runs
    assign arready   = !busy && !stall;

    // beats back to back, 8 bytes each, low word first
    assign beat_addr = base + {27'd0, beat, 3'b000};
    assign rvalid    = busy;
    assign rlast     = busy && (beat == 2'(icache_pkg::BEAT_NUM - 1));
    assign rdata     = busy ? {mem_word(beat_addr + 32'd4), mem_word(beat_addr)} : '0;

endmodule

`default_nettype wire

//--- testbench/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int FETCH_LIMIT = 200;

    logic        I_clk = 1'b0;
    logic        I_rst = 1'b1;
    logic        cpu_req = 1'b0;
    logic [31:0] cpu_addr = '0;
    logic [31:0] cpu_inst;
    logic        cpu_rvalid;
    logic        mem_arready;
    logic        mem_rvalid;
    logic [63:0] mem_rdata;
    logic        mem_rlast;
    logic        mem_arvalid;
    logic [31:0] mem_araddr;

    // arready gap generator
    logic        ar_stall = 1'b0;
    logic        throttle = 1'b0;
    logic [31:0] gap_state = 32'd23725;
    logic [31:0] addr_state = 32'd23725;
    // per fetch bookkeeping
    logic        started = 1'b0;
    logic        req_new = 1'b0;
    logic        exp_hit = 1'b0;
    logic        hung = 1'b0;
    int          hs_count = 0;
    // resident tags as predicted from the victim rule
    logic                           sb_valid [icache_pkg::SET_NUM][icache_pkg::WAY_NUM];
    logic [icache_pkg::TAG_LEN-1:0] sb_tag [icache_pkg::SET_NUM][icache_pkg::WAY_NUM];
    // one counter per check
    int err_idle = 0;
    int err_araddr = 0;
    int err_hold = 0;
    int err_bursts = 0;
    int err_latency = 0;
    int err_inst = 0;
    int err_hit_bus = 0;
    int timeouts = 0;

    always #10 I_clk = ~I_clk;

    icache_top i_dut (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_inst    (cpu_inst),
        .cpu_rvalid  (cpu_rvalid),
        .mem_arready (mem_arready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_rlast   (mem_rlast),
        .mem_arvalid (mem_arvalid),
        .mem_araddr  (mem_araddr)
    );

    axi_mem_model i_mem (
        .I_clk   (I_clk),
        .I_rst   (I_rst),
        .stall   (ar_stall),
        .arvalid (mem_arvalid),
        .araddr  (mem_araddr),
        .arready (mem_arready),
        .rvalid  (mem_rvalid),
        .rdata   (mem_rdata),
        .rlast   (mem_rlast)
    );

    // xorshift32
    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word at byte address A is A xor C0DE0000
    function automatic logic [31:0] expected_inst(input logic [31:0] a);
        return a ^ 32'hC0DE_0000;
    endfunction

    // random arready gaps, only while throttling
    always @(posedge I_clk) begin
        gap_state <= next_rand(gap_state);
        ar_stall  <= throttle && (gap_state[1:0] != 2'b00);
    end

    // address handshakes since the last returned word
    always @(posedge I_clk) begin
        if (I_rst || cpu_rvalid) begin
            hs_count <= 0;
        end else if (mem_arvalid && mem_arready) begin
            hs_count <= hs_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // quiet between reset and the first request
    a_idle_quiet : assert property (@(posedge I_clk) disable iff (I_rst)
        !started |-> !cpu_rvalid && !mem_arvalid)
        else begin
            err_idle++;
            $display("cpu_rvalid or mem_arvalid rose before any request at %0t", $time);
        end

    // burst address is the fetch address with offset cleared
    a_burst_addr : assert property (@(posedge I_clk) disable iff (I_rst)
        mem_arvalid && mem_arready |->
            mem_araddr == ((cpu_addr >> icache_pkg::OFFT_LEN) << icache_pkg::OFFT_LEN))
        else begin
            err_araddr++;
            $display("Mismatch at %0t: mem_araddr got %h expected %h", $time, mem_araddr,
                     (cpu_addr >> icache_pkg::OFFT_LEN) << icache_pkg::OFFT_LEN);
        end

    // back-pressure holds the request steady
    a_ar_hold : assert property (@(posedge I_clk) disable iff (I_rst)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else begin
            err_hold++;
            $display("mem_arvalid or mem_araddr changed before the handshake at %0t", $time);
        end

    // one burst per miss, none per hit
    a_burst_count : assert property (@(posedge I_clk) disable iff (I_rst)
        cpu_rvalid |-> hs_count == (exp_hit ? 0 : 1))
        else begin
            err_bursts++;
            $display("Mismatch at %0t: hs_count got %0d expected %0d", $time,
                     hs_count, exp_hit ? 0 : 1);
        end

    // hit answers in the cycle after acceptance, a miss never does
    a_hit_latency : assert property (@(posedge I_clk) disable iff (I_rst)
        req_new |=> cpu_rvalid == exp_hit)
        else begin
            err_latency++;
            $display("Mismatch at %0t: cpu_rvalid got %b expected %b", $time,
                     cpu_rvalid, exp_hit);
        end

    a_inst_value : assert property (@(posedge I_clk) disable iff (I_rst)
        cpu_rvalid |-> cpu_inst == expected_inst(cpu_addr))
        else begin
            err_inst++;
            $display("Mismatch at %0t: cpu_inst got %h expected %h", $time,
                     cpu_inst, expected_inst(cpu_addr));
        end

    a_hit_no_bus : assert property (@(posedge I_clk) disable iff (I_rst)
        cpu_req && exp_hit |-> !mem_arvalid)
        else begin
            err_hit_bus++;
            $display("mem_arvalid raised during a predicted hit at %0t", $time);
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // predict hit or miss, then hold the request until cpu_rvalid
    task automatic fetch(input logic [31:0] addr);
        logic [icache_pkg::TAG_LEN-1:0]   tag;
        logic [icache_pkg::INDEX_LEN-1:0] idx;
        logic                             way;
        logic                             hit_now;
        logic                             done;
        int                               cycles;
        if (!hung) begin
            tag     = addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_LEN];
            idx     = addr[icache_pkg::OFFT_LEN +: icache_pkg::INDEX_LEN];
            hit_now = (sb_valid[idx][0] && sb_tag[idx][0] == tag)
                      || (sb_valid[idx][1] && sb_tag[idx][1] == tag);
            // way 1 only when way 0 is taken and way 1 is empty
            if (!hit_now) begin
                way               = sb_valid[idx][0] && !sb_valid[idx][1];
                sb_valid[idx][way] = 1'b1;
                sb_tag[idx][way]   = tag;
            end
            started  <= 1'b1;
            req_new  <= 1'b1;
            exp_hit  <= hit_now;
            cpu_req  <= 1'b1;
            cpu_addr <= addr;
            done   = 1'b0;
            cycles = 0;
            while (!done && cycles < FETCH_LIMIT) begin
                @(posedge I_clk);
                req_new <= 1'b0;
                cycles++;
                done = cpu_rvalid;
            end
            if (!done) begin
                hung = 1'b1;
                timeouts++;
                $display("timeout: no cpu_rvalid within %0d cycles for address %h",
                         FETCH_LIMIT, addr);
            end
        end
    endtask

    initial begin : stimulus
        int    total;
        string counts;
        for (int s = 0; s < icache_pkg::SET_NUM; s++) begin
            sb_valid[s][0] = 1'b0;
            sb_valid[s][1] = 1'b0;
        end
        repeat (10) @(posedge I_clk);
        I_rst <= 1'b0;
        // idle stretch after reset
        repeat (5) @(posedge I_clk);

        // cold miss, then every word of the line hits
        fetch(32'h0000_1004);
        for (int w = 0; w < 8; w++) begin
            fetch(32'h0000_1000 + 32'(4 * w));
        end

        // set 0 with tags 2, 3 and 4
        fetch(32'h0000_1808);
        fetch(32'h0000_1008);
        fetch(32'h0000_180C);
        // third tag evicts way 0
        fetch(32'h0000_2008);
        fetch(32'h0000_1810);
        fetch(32'h0000_1008);
        fetch(32'h0000_1814);

        // random fetches over 8 KiB with arready gaps
        throttle <= 1'b1;
        for (int n = 0; n < 48; n++) begin
            addr_state = next_rand(addr_state);
            fetch(addr_state & 32'h0000_1FFC);
        end
        throttle <= 1'b0;
        cpu_req  <= 1'b0;
        repeat (5) @(posedge I_clk);

        total = err_idle + err_araddr + err_hold + err_bursts + err_latency
                + err_inst + err_hit_bus + timeouts;
        counts = $sformatf("idle=%0d araddr=%0d arhold=%0d bursts=%0d",
                           err_idle, err_araddr, err_hold, err_bursts);
        $display("errors: %s latency=%0d inst=%0d hitbus=%0d timeouts=%0d",
                 counts, err_latency, err_inst, err_hit_bus, timeouts);
        if (total == 0 && !hung) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/icache_pkg.sv
src/sram_bank.sv
icache/icache_tag_store.sv
icache/icache_line_buffer.sv
icache/icache_ctrl.sv
src/icache_top.sv
testbench/axi_mem_model.sv
testbench/tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module tb_icache \
    -f files.f \
    -o Vtb_icache

./obj_dir/Vtb_icache | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
